// File: design/icache_geom_pkg.sv
package icache_geom_pkg;

    // fetch address layout: tag[31:7] | set[6:4] | word[3:2] | byte[1:0]
    localparam int ADDR_W = 32;

    // organisation of the cache
    localparam int WAYS       = 4;
    localparam int SETS       = 8;
    localparam int LINE_WORDS = 4; // 32-bit words per line

    // field widths of the fetch address
    localparam int OFFSET_BITS = 4;                                 // byte offset within a line
    localparam int SET_BITS    = $clog2(SETS);                      // 3
    localparam int TAG_BITS    = ADDR_W - SET_BITS - OFFSET_BITS;   // 25
    localparam int WAY_BITS    = $clog2(WAYS);
    localparam int WORD_BITS   = $clog2(LINE_WORDS);

    // stored in the tag arrays, compared on every lookup
    typedef logic [TAG_BITS-1:0] tag_t;

    // row address shared by all way arrays and the set state
    typedef logic [SET_BITS-1:0] set_idx_t;

    // way number, used for hit way, victim and lru entries
    typedef logic [WAY_BITS-1:0] way_idx_t;

    // word inside a line, taken from address bits 3:2
    typedef logic [WORD_BITS-1:0] word_idx_t;

endpackage

// File: design/icache_bus_pkg.sv
package icache_bus_pkg;

    // fetch side returns single instructions
    localparam int INSTR_W = 32;

    // memory side moves whole lines, four words
    localparam int LINE_W = 128;

    // one instruction word on fetch_instr_o
    typedef logic [INSTR_W-1:0] instr_t;

    // one cache line, word 0 in bits 31:0, word 3 in bits 127:96
    typedef logic [LINE_W-1:0] line_t;

endpackage

// File: design/icache_way_ram.sv
`timescale 1ns/1ps

// one way of the cache, one entry per set
// the top level builds tag ways and line ways out of this
module icache_way_ram #(
    parameter type payload_t = logic,                  // tag_t or line_t
    parameter int  DEPTH     = icache_geom_pkg::SETS
) (
    input  logic                      clk_i,
    input  logic                      rd_en_i,   // read row idx_i, data valid next cycle
    input  logic                      wr_en_i,   // write wr_data_i into row idx_i
    input  icache_geom_pkg::set_idx_t idx_i,
    input  payload_t                  wr_data_i,
    output payload_t                  rd_data_o
);

    payload_t mem_q [DEPTH]; // contents are meaningless until the valid bit is set

    // write port
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            mem_q[idx_i] <= wr_data_i;
        end
    end

    // registered read, output holds between reads
    // the controller never reads and writes in the same cycle
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rd_data_o <= mem_q[idx_i];
        end
    end

endmodule

// File: design/icache_set_state.sv
`timescale 1ns/1ps

// valid bits and true-lru order for every set
module icache_set_state (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  icache_geom_pkg::set_idx_t set_i,       // set of the request in flight
    input  logic                      touch_i,     // hit, make touch_way_i most recent
    input  icache_geom_pkg::way_idx_t touch_way_i,
    input  logic                      fill_i,      // refill done, also sets valid
    input  logic                      flush_i,     // clear all valid bits
    output logic [icache_geom_pkg::WAYS-1:0] valid_o,
    output icache_geom_pkg::way_idx_t victim_o
);
    import icache_geom_pkg::*;

    logic [WAYS-1:0] valid_q [SETS];
    way_idx_t        order_q [SETS][WAYS]; // entry 0 most recent, entry WAYS-1 least recent
    way_idx_t        order_d [WAYS];       // order of set_i after moving touch_way_i up
    logic            passed;               // touched way already shifted out

    assign valid_o = valid_q[set_i];

    // entries above the touched way slide down by one, the rest stay
    always_comb begin
        passed     = 1'b0;
        order_d[0] = touch_way_i;
        for (int i = 1; i < WAYS; i++) begin
            if (order_q[set_i][i-1] == touch_way_i) passed = 1'b1;
            order_d[i] = passed ? order_q[set_i][i] : order_q[set_i][i-1];
        end
    end

    // lowest invalid way first, else lru
    always_comb begin
        victim_o = order_q[set_i][WAYS-1];
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (!valid_q[set_i][w]) victim_o = way_idx_t'(w);
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= '0;
                for (int i = 0; i < WAYS; i++) begin
                    order_q[s][i] <= way_idx_t'(WAYS - 1 - i); // way 0 ends up least recent
                end
            end
        end else if (flush_i) begin
            for (int s = 0; s < SETS; s++) valid_q[s] <= '0; // lru order is kept
        end else begin
            if (touch_i || fill_i) begin
                for (int i = 0; i < WAYS; i++) order_q[set_i][i] <= order_d[i];
            end
            if (fill_i) valid_q[set_i][touch_way_i] <= 1'b1;
        end
    end

endmodule

// File: design/icache_hit_select.sv
`timescale 1ns/1ps

// tag compare over all ways and word pick from the hitting line
module icache_hit_select (
    input  icache_geom_pkg::tag_t                              tag_i,      // request tag
    input  icache_geom_pkg::word_idx_t                         word_i,     // request word
    input  icache_geom_pkg::tag_t [icache_geom_pkg::WAYS-1:0]  way_tag_i,  // from tag arrays
    input  logic [icache_geom_pkg::WAYS-1:0]                   valid_i,    // from set state
    input  icache_bus_pkg::line_t [icache_geom_pkg::WAYS-1:0]  way_line_i, // from line arrays
    output logic                                               hit_o,
    output icache_geom_pkg::way_idx_t                          hit_way_o,
    output icache_bus_pkg::instr_t                             instr_o
);
    import icache_geom_pkg::*;
    import icache_bus_pkg::*;

    logic [WAYS-1:0] match;             // one bit per way
    instr_t          words [LINE_WORDS]; // hit line split into words

    // invalid ways never match, whatever their stale tag holds
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            match[w] = valid_i[w] && (way_tag_i[w] == tag_i);
        end
    end

    assign hit_o = |match;

    // priority encode, lowest way wins
    // at most one way can match since a line is only ever filled once per set
    always_comb begin
        hit_way_o = '0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (match[w]) hit_way_o = way_idx_t'(w);
        end
    end

    // word 0 sits in the low bits of the line
    always_comb begin
        for (int k = 0; k < LINE_WORDS; k++) begin
            words[k] = way_line_i[hit_way_o][k*INSTR_W +: INSTR_W];
        end
    end

    assign instr_o = words[word_i]; // don't care when hit_o is low

endmodule

// File: design/icache_ctrl.sv
`timescale 1ns/1ps

// fetch acceptance, lookup sequencing and line refill
module icache_ctrl (
    input  logic                                 clk_i,
    input  logic                                 arst_n_i,
    input  logic                                 fetch_valid_i,
    input  logic [icache_geom_pkg::ADDR_W-1:0]   fetch_addr_i,
    output logic                                 fetch_ready_o,
    input  logic                                 flush_i,
    input  logic                                 hit_i,
    input  icache_geom_pkg::way_idx_t            hit_way_i,
    input  icache_bus_pkg::instr_t               instr_i,
    input  icache_geom_pkg::way_idx_t            victim_i,
    input  logic                                 mem_ack_i,
    output logic                                 mem_req_o,
    output logic [icache_geom_pkg::ADDR_W-1:0]   mem_addr_o,
    output logic                                 rd_en_o,    // to every way array
    output logic [icache_geom_pkg::WAYS-1:0]     wr_en_o,    // one-hot, victim way only
    output icache_geom_pkg::set_idx_t            set_o,
    output icache_geom_pkg::tag_t                tag_o,      // compare tag and tag write data
    output icache_geom_pkg::word_idx_t           word_o,
    output logic                                 touch_o,
    output logic                                 fill_o,
    output icache_geom_pkg::way_idx_t            touch_way_o,
    output logic                                 flush_o,
    output logic                                 fetch_rvalid_o,
    output icache_bus_pkg::instr_t               fetch_instr_o
);
    import icache_geom_pkg::*;

    typedef enum logic [2:0] {IDLE, READ, COMPARE, REFILL, WRITE} state_e;

    state_e            state_q, state_d;
    logic [ADDR_W-1:0] addr_q; // accepted fetch address, held until the answer
    logic              accept;

    // address fields of the request in flight
    assign tag_o      = addr_q[ADDR_W-1 -: TAG_BITS];
    assign set_o      = addr_q[OFFSET_BITS +: SET_BITS];
    assign word_o     = addr_q[OFFSET_BITS-1 -: WORD_BITS];
    assign mem_addr_o = {tag_o, set_o, {OFFSET_BITS{1'b0}}}; // line aligned

    assign fetch_ready_o = (state_q == IDLE) && !flush_i; // flush cycle blocks acceptance
    assign accept        = fetch_valid_i && fetch_ready_o;
    assign flush_o       = (state_q == IDLE) && flush_i;
    assign rd_en_o       = (state_q == READ);
    assign mem_req_o     = (state_q == REFILL);    // held until the ack edge
    assign touch_o       = (state_q == COMPARE) && hit_i;
    assign fill_o        = (state_q == WRITE);     // line already in the arrays
    assign touch_way_o   = fill_o ? victim_i : hit_way_i;

    // line and tag go into the victim on the ack edge, straight from the bus
    always_comb begin
        wr_en_o = '0;
        if (mem_req_o && mem_ack_i) wr_en_o[victim_i] = 1'b1;
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (accept) state_d = READ;
            READ:    state_d = COMPARE;               // arrays read this cycle
            COMPARE: state_d = hit_i ? IDLE : REFILL;
            REFILL:  if (mem_ack_i) state_d = WRITE;
            WRITE:   state_d = READ;                  // look up again, now a hit
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q        <= IDLE;
            fetch_rvalid_o <= 1'b0;
        end else begin
            state_q        <= state_d;
            fetch_rvalid_o <= touch_o; // one cycle pulse
        end
    end

    // payload registers
    always_ff @(posedge clk_i) begin
        if (accept)  addr_q        <= fetch_addr_i;
        if (touch_o) fetch_instr_o <= instr_i;
    end

endmodule

// File: design/icache_top.sv
`timescale 1ns/1ps

// four-way instruction cache, 8 sets of 16-byte lines
module icache_top (
    input  logic                               clk_i,
    input  logic                               arst_n_i,
    // fetch port
    input  logic                               fetch_valid_i,
    input  logic [icache_geom_pkg::ADDR_W-1:0] fetch_addr_i,
    output logic                               fetch_ready_o,
    output logic                               fetch_rvalid_o,
    output icache_bus_pkg::instr_t             fetch_instr_o,
    input  logic                               flush_i,
    // memory port, read only
    output logic                               mem_req_o,
    output logic [icache_geom_pkg::ADDR_W-1:0] mem_addr_o,
    input  logic                               mem_ack_i,
    input  icache_bus_pkg::line_t              mem_line_i
);
    import icache_geom_pkg::*;
    import icache_bus_pkg::*;

    logic                   rd_en;
    logic [WAYS-1:0]        wr_en;
    set_idx_t               set_idx;
    tag_t                   req_tag;
    word_idx_t              req_word;
    logic                   hit, touch, fill, flush;
    way_idx_t               hit_way, victim, touch_way;
    instr_t                 hit_instr;
    logic [WAYS-1:0]        valid;
    tag_t  [WAYS-1:0]       way_tag;  // registered reads of the tag ways
    line_t [WAYS-1:0]       way_line; // registered reads of the line ways

    icache_ctrl i_ctrl (
        .clk_i, .arst_n_i, .fetch_valid_i, .fetch_addr_i, .fetch_ready_o, .flush_i,
        .hit_i(hit), .hit_way_i(hit_way), .instr_i(hit_instr), .victim_i(victim),
        .mem_ack_i, .mem_req_o, .mem_addr_o,
        .rd_en_o(rd_en), .wr_en_o(wr_en), .set_o(set_idx), .tag_o(req_tag), .word_o(req_word),
        .touch_o(touch), .fill_o(fill), .touch_way_o(touch_way), .flush_o(flush),
        .fetch_rvalid_o, .fetch_instr_o
    );

    icache_set_state i_set_state (
        .clk_i, .arst_n_i, .set_i(set_idx), .touch_i(touch), .touch_way_i(touch_way),
        .fill_i(fill), .flush_i(flush), .valid_o(valid), .victim_o(victim)
    );

    icache_hit_select i_hit_select (
        .tag_i(req_tag), .word_i(req_word), .way_tag_i(way_tag), .valid_i(valid),
        .way_line_i(way_line), .hit_o(hit), .hit_way_o(hit_way), .instr_o(hit_instr)
    );

    // tag and line arrays per way, written together on refill
    for (genvar w = 0; w < WAYS; w++) begin : g_way
        icache_way_ram #(.payload_t(tag_t)) i_tag_ram (
            .clk_i, .rd_en_i(rd_en), .wr_en_i(wr_en[w]), .idx_i(set_idx),
            .wr_data_i(req_tag), .rd_data_o(way_tag[w])
        );
        icache_way_ram #(.payload_t(line_t)) i_line_ram (
            .clk_i, .rd_en_i(rd_en), .wr_en_i(wr_en[w]), .idx_i(set_idx),
            .wr_data_i(mem_line_i), .rd_data_o(way_line[w])
        );
    end

endmodule

// File: dv/icache_assertions.sv
`timescale 1ns/1ps

// handshake rules of the fetch and memory ports, bound into icache_ctrl
module icache_assertions (
    input logic                               clk_i,
    input logic                               arst_n_i,
    input logic                               fetch_valid_i,
    input logic                               fetch_ready_o,
    input logic                               fetch_rvalid_o,
    input logic                               mem_req_o,
    input logic                               mem_ack_i,
    input logic [icache_geom_pkg::ADDR_W-1:0] mem_addr_o
);
    int unsigned fails = 0; // failed checks so far
    logic        busy_q;    // request accepted, answer not yet seen

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) busy_q <= 1'b0;
        else if (fetch_valid_i && fetch_ready_o) busy_q <= 1'b1; // new request wins
        else if (fetch_rvalid_o) busy_q <= 1'b0;
    end

    // one request in flight, ready only returns with the answer
    a_ready_low: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        busy_q && !fetch_rvalid_o |-> !fetch_ready_o)
        else begin
            $error("fetch_ready_o high while a request is in flight");
            fails++;
        end

    // refill request and its address hold until the ack edge
    a_req_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        mem_req_o && !mem_ack_i |=> mem_req_o && $stable(mem_addr_o))
        else begin
            $error("mem_req_o or mem_addr_o changed before mem_ack_i");
            fails++;
        end

    a_no_answer_in_refill: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $rose(fetch_rvalid_o) |-> !mem_req_o)
        else begin
            $error("fetch_rvalid_o rose while mem_req_o was high");
            fails++;
        end

endmodule

// File: dv/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;
    import icache_geom_pkg::*;
    import icache_bus_pkg::*;

    localparam int N_RANDOM     = 150;                          // fetches per random phase
    localparam int MAX_REQUESTS = 8 + 2 * N_RANDOM + SETS * WAYS;
    localparam int MAX_CYCLES   = MAX_REQUESTS * 12 + 100;
    localparam bit [7:0] HIT_PAT = 8'b0100_0000;                // bit i set where access i hits

    logic              clk_i = 1'b0;
    logic              arst_n_i;
    logic              fetch_valid_i;
    logic              fetch_ready_o;
    logic              fetch_rvalid_o;
    logic              flush_i;
    logic [ADDR_W-1:0] fetch_addr_i;
    logic [ADDR_W-1:0] mem_addr_o;
    instr_t            fetch_instr_o;
    logic              mem_req_o;
    logic              mem_ack_i;
    line_t             mem_line_i;

    tag_t              m_tag   [SETS][WAYS]; // reference model of the tag store
    logic              m_valid [SETS][WAYS];
    way_idx_t          m_order [SETS][WAYS]; // entry 0 most recent
    logic [ADDR_W-1:0] exp_line_addr;        // line the next refill has to ask for
    int                cycles = 0;
    int                mem_reqs = 0;
    int                instr_errs = 0;
    int                addr_errs = 0;
    int                proto_errs = 0;

    icache_top i_icache_top (
        .clk_i, .arst_n_i, .fetch_valid_i, .fetch_addr_i, .fetch_ready_o, .fetch_rvalid_o,
        .fetch_instr_o, .flush_i, .mem_req_o, .mem_addr_o, .mem_ack_i, .mem_line_i
    );

    bind icache_ctrl icache_assertions i_assertions (
        .clk_i, .arst_n_i, .fetch_valid_i, .fetch_ready_o, .fetch_rvalid_o,
        .mem_req_o, .mem_ack_i, .mem_addr_o
    );

    always #10 clk_i = ~clk_i;

    // word k of line A reads A + 4k with the upper half inverted
    function automatic instr_t expected_word(input logic [ADDR_W-1:0] addr);
        return {addr[ADDR_W-1:2], 2'b00} ^ 32'hFFFF_0000;
    endfunction

    function automatic line_t make_line(input logic [ADDR_W-1:0] line_addr);
        line_t line;
        for (int k = 0; k < LINE_WORDS; k++) begin
            line[k*INSTR_W +: INSTR_W] = (line_addr + ADDR_W'(4 * k)) ^ 32'hFFFF_0000;
        end
        return line;
    endfunction

    // few tags per set so the ways overflow and lru replacement kicks in
    function automatic logic [ADDR_W-1:0] random_addr();
        tag_t      tag;
        set_idx_t  set;
        word_idx_t word;
        tag  = tag_t'(25'h0_0a50 + $urandom_range(5, 0));
        set  = set_idx_t'($urandom_range(SETS - 1, 0));
        word = word_idx_t'($urandom_range(LINE_WORDS - 1, 0));
        return {tag, set, word, 2'b00};
    endfunction

    // predicts hit or miss and updates the model like a lookup plus refill
    function automatic bit model_access(input logic [ADDR_W-1:0] addr);
        tag_t     tag;
        set_idx_t set;
        way_idx_t way;
        bit       hit;
        int       pos;
        tag = addr[ADDR_W-1 -: TAG_BITS];
        set = addr[OFFSET_BITS +: SET_BITS];
        hit = 1'b0;
        way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (!hit && m_valid[set][w] && m_tag[set][w] == tag) begin
                hit = 1'b1;
                way = way_idx_t'(w);
            end
        end
        if (!hit) begin
            way = m_order[set][WAYS-1];                       // least recent
            for (int w = WAYS - 1; w >= 0; w--) begin
                if (!m_valid[set][w]) way = way_idx_t'(w);    // free way beats lru
            end
            m_tag[set][way]   = tag;
            m_valid[set][way] = 1'b1;
        end
        pos = 0;
        for (int i = 0; i < WAYS; i++) begin
            if (m_order[set][i] == way) pos = i;
        end
        for (int i = pos; i > 0; i--) m_order[set][i] = m_order[set][i-1];
        m_order[set][0] = way;
        return hit;
    endfunction

    task automatic check_instr(input instr_t got, input instr_t exp,
                               input logic [ADDR_W-1:0] addr);
        if (got !== exp) begin
            instr_errs++;
            $display("[ERROR] %0t: fetch 0x%08h returned 0x%08h, expected 0x%08h",
                     $time, addr, got, exp);
        end
    endtask

    task automatic check_line_addr(input logic [ADDR_W-1:0] got, input logic [ADDR_W-1:0] exp);
        if (got !== exp) begin
            addr_errs++;
            $display("[ERROR] %0t: refill of 0x%08h, expected 0x%08h", $time, got, exp);
        end
    endtask

    task automatic protocol_error(input string msg);
        proto_errs++;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    task automatic fetch_and_check(input logic [ADDR_W-1:0] addr, output bit hit);
        int acc_cycle;
        int reqs_before;
        hit           = model_access(addr);
        exp_line_addr = {addr[ADDR_W-1:OFFSET_BITS], OFFSET_BITS'(0)};
        reqs_before   = mem_reqs;
        @(negedge clk_i);
        while (!fetch_ready_o) @(negedge clk_i);
        fetch_valid_i = 1'b1;
        fetch_addr_i  = addr;
        @(negedge clk_i);                     // acceptance edge just passed
        acc_cycle     = cycles;
        fetch_valid_i = 1'b0;
        while (!fetch_rvalid_o) @(negedge clk_i);
        check_instr(fetch_instr_o, expected_word(addr), addr);
        if (hit && (cycles - acc_cycle) != 2) begin
            protocol_error($sformatf("hit on 0x%08h answered after %0d cycles",
                                     addr, cycles - acc_cycle));
        end
        if (mem_reqs != reqs_before + (hit ? 0 : 1)) begin
            protocol_error($sformatf("fetch 0x%08h made %0d refills, expected %0d",
                                     addr, mem_reqs - reqs_before, hit ? 0 : 1));
        end
    endtask

    task automatic flush_cache();
        @(negedge clk_i);
        while (!fetch_ready_o) @(negedge clk_i);
        flush_i       = 1'b1;
        fetch_valid_i = 1'b1;                 // offered in the flush cycle and has to wait
        fetch_addr_i  = random_addr();
        @(negedge clk_i);
        flush_i       = 1'b0;
        fetch_valid_i = 1'b0;
        @(negedge clk_i);                     // a fetch taken with the flush would be in flight
        if (!fetch_ready_o) protocol_error("fetch accepted in the flush cycle");
        foreach (m_valid[s, w]) m_valid[s][w] = 1'b0; // recency order survives a flush
    endtask

    // five tags into set 5 and then a revisit in the order t0 t1 t2 t3 t4 t0 t2 t1
    task automatic replacement_test();
        int seq [8] = '{0, 1, 2, 3, 4, 0, 2, 1};
        bit hit;
        for (int i = 0; i < 8; i++) begin
            fetch_and_check({tag_t'(25'h100 + seq[i]), set_idx_t'(5), word_idx_t'(i), 2'b00},
                            hit);
            if (hit != HIT_PAT[i]) begin
                protocol_error($sformatf("replacement access %0d predicted %s", i,
                                         hit ? "hit" : "miss"));
            end
        end
    endtask

    task automatic flush_test();
        logic [ADDR_W-1:0] lines [$];
        bit                hit;
        foreach (m_valid[s, w]) begin
            if (m_valid[s][w]) lines.push_back({m_tag[s][w], set_idx_t'(s), OFFSET_BITS'(0)});
        end
        flush_cache();
        foreach (lines[i]) begin
            fetch_and_check(lines[i] | ADDR_W'($urandom_range(3, 0) << 2), hit);
        end
    endtask

    task automatic random_fetches(input int n);
        bit hit;
        repeat (n) fetch_and_check(random_addr(), hit);
    endtask

    // memory model that acks each refill after 0 to 5 cycles
    always begin
        int delay;
        @(negedge clk_i);
        if (mem_req_o) begin
            mem_reqs++;
            check_line_addr(mem_addr_o, exp_line_addr);
            delay = $urandom_range(5, 0);
            repeat (delay) @(negedge clk_i);
            mem_ack_i  = 1'b1;
            mem_line_i = make_line(mem_addr_o);
            @(negedge clk_i);
            mem_ack_i  = 1'b0;
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: run still busy after %0d cycles", MAX_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        void'($urandom(60));
        arst_n_i      = 1'b0;
        fetch_valid_i = 1'b0;
        fetch_addr_i  = '0;
        flush_i       = 1'b0;
        mem_ack_i     = 1'b0;
        mem_line_i    = '0;
        foreach (m_order[s, i]) begin
            m_valid[s][i] = 1'b0;
            m_tag[s][i]   = '0;
            m_order[s][i] = way_idx_t'(WAYS - 1 - i);    // way 0 least recent
        end
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        arst_n_i = 1'b1;
        replacement_test();
        random_fetches(N_RANDOM);
        flush_test();
        random_fetches(N_RANDOM);
        @(negedge clk_i);
        $display("errors: instr %0d, refill address %0d, protocol %0d, assertion %0d",
                 instr_errs, addr_errs, proto_errs, i_icache_top.i_ctrl.i_assertions.fails);
        if (instr_errs + addr_errs + proto_errs + i_icache_top.i_ctrl.i_assertions.fails == 0)
        begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: vlog.f
design/icache_geom_pkg.sv
design/icache_bus_pkg.sv
design/icache_way_ram.sv
design/icache_set_state.sv
design/icache_hit_select.sv
design/icache_ctrl.sv
design/icache_top.sv
dv/icache_assertions.sv
dv/icache_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the instruction cache testbench with Verilator
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module icache_tb -Mdir obj_dir -f vlog.f

./obj_dir/Vicache_tb +verilator+error+limit+1000 | tee sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation passed"
